//--- design/sparc_pkg.sv
`default_nettype none

package sparc_pkg;

	typedef logic [31:0] word_t;     // Data and instruction word
	typedef logic [31:0] addr_t;     // Byte address
	typedef logic [4:0]  reg_addr_t; // Register index
	typedef logic [5:0]  op3_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [1:0]  wb_sel_t;   // Write-back source

	// Top two bits of the instruction
	localparam logic [1:0] OP_BRANCH = 2'b00;
	localparam logic [1:0] OP_CALL   = 2'b01;
	localparam logic [1:0] OP_ARITH  = 2'b10;
	localparam logic [1:0] OP_MEM    = 2'b11;

	localparam op3_t OP3_ADD = 6'b000000;
	localparam op3_t OP3_AND = 6'b000001;
	localparam op3_t OP3_OR  = 6'b000010;
	localparam op3_t OP3_XOR = 6'b000011;
	localparam op3_t OP3_SUB = 6'b000100;
	localparam op3_t OP3_LD  = 6'b000000; // Same codes as add/sub, but under OP_MEM
	localparam op3_t OP3_ST  = 6'b000100;

	localparam logic [3:0] COND_BA = 4'b1000; // Branch always
	localparam logic [3:0] COND_BN = 4'b0000; // Branch never

	localparam reg_addr_t LINK_REG = 5'd15; // CALL return address lands here

	localparam int RAM_WORDS  = 256;
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS); // Word index width
	localparam addr_t RESET_PC = 32'h0000_0000;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_AND = 3'd1;
	localparam alu_op_t ALU_OR  = 3'd2;
	localparam alu_op_t ALU_XOR = 3'd3;
	localparam alu_op_t ALU_SUB = 3'd4;

	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MDR = 2'd1; // Load data
	localparam wb_sel_t WB_PC  = 2'd2; // CALL link value

	typedef enum logic [2:0] {
		FETCH,
		EXECUTE,
		MEM_ADDR,
		MEM_WAIT,
		WRITE_BACK
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  wire sparc_pkg::word_t     ir,
	input  wire sparc_pkg::word_t     rs1_data,
	input  wire sparc_pkg::word_t     rs2_data,
	input  wire sparc_pkg::alu_op_t   alu_op,
	input  wire                       imm_select,
	output sparc_pkg::word_t          alu_result
);

	sparc_pkg::word_t simm;
	sparc_pkg::word_t operand_b;

	assign simm      = {{19{ir[12]}}, ir[12:0]}; // simm13 sign extended
	assign operand_b = imm_select ? simm : rs2_data;

	always_comb begin
		case (alu_op)
			sparc_pkg::ALU_AND: alu_result = rs1_data & operand_b;
			sparc_pkg::ALU_OR:  alu_result = rs1_data | operand_b;
			sparc_pkg::ALU_XOR: alu_result = rs1_data ^ operand_b;
			sparc_pkg::ALU_SUB: alu_result = rs1_data - operand_b;
			default:            alu_result = rs1_data + operand_b; // add, addresses
		endcase
	end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
	input  wire                       Clk,
	input  wire                       RESET,
	input  wire sparc_pkg::reg_addr_t rs1_addr,
	input  wire sparc_pkg::reg_addr_t rs2_addr,
	input  wire sparc_pkg::reg_addr_t rd_addr,
	input  wire                       rf_write,
	input  wire sparc_pkg::word_t     write_data,
	output sparc_pkg::word_t          rs1_data,
	output sparc_pkg::word_t          rs2_data
);

	sparc_pkg::word_t regs [32];

	// r0 is hardwired
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge Clk) begin
		if (RESET) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (rf_write && rd_addr != '0) begin
			regs[rd_addr] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- design/ram.sv
`timescale 1ns/100ps
`default_nettype none

module ram (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire                   mem_en,
	input  wire                   mem_we,
	input  wire sparc_pkg::addr_t mem_addr,
	input  wire sparc_pkg::word_t mem_wdata,
	input  wire                   boot_write,
	input  wire sparc_pkg::addr_t boot_addr,
	input  wire sparc_pkg::word_t boot_data,
	output sparc_pkg::word_t      mem_rdata
);

	sparc_pkg::word_t mem [sparc_pkg::RAM_WORDS];

	always_ff @(posedge Clk) begin
		if (RESET && boot_write)
			mem[boot_addr[sparc_pkg::RAM_ADDR_W+1:2]] <= boot_data; // Loader path
		else if (mem_en && mem_we)
			mem[mem_addr[sparc_pkg::RAM_ADDR_W+1:2]] <= mem_wdata;
		if (mem_en)
			mem_rdata <= mem[mem_addr[sparc_pkg::RAM_ADDR_W+1:2]]; // Old data on write
	end

endmodule

`default_nettype wire

//--- design/memory_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module memory_arbiter (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire                   fetch_req,
	input  wire sparc_pkg::addr_t fetch_addr,
	input  wire                   data_req,
	input  wire sparc_pkg::addr_t data_addr,
	input  wire                   data_write,
	input  wire sparc_pkg::word_t data_wdata,
	input  wire sparc_pkg::word_t mem_rdata,
	output logic                  fetch_grant,
	output logic                  data_grant,
	output logic                  mem_en,
	output logic                  mem_we,
	output sparc_pkg::addr_t      mem_addr,
	output sparc_pkg::word_t      mem_wdata,
	output logic                  fetch_done,
	output logic                  data_done,
	output sparc_pkg::word_t      fetch_rdata,
	output sparc_pkg::word_t      data_rdata
);

	logic own_fetch, own_data; // Owner of the access in flight

	assign data_grant  = data_req;               // Data side wins
	assign fetch_grant = fetch_req && !data_req; // Fetch waits otherwise
	assign mem_en      = data_req || fetch_req;
	assign mem_we      = data_req && data_write;
	assign mem_addr    = data_req ? data_addr : fetch_addr;
	assign mem_wdata   = data_wdata;

	assign fetch_done  = own_fetch;
	assign data_done   = own_data;
	assign fetch_rdata = mem_rdata;
	assign data_rdata  = mem_rdata;

	always_ff @(posedge Clk) begin
		if (RESET) begin
			own_fetch <= 1'b0;
			own_data  <= 1'b0;
		end else begin
			own_fetch <= fetch_grant;
			own_data  <= data_grant;
		end
	end

	// Requesters drop their request once granted
	a_drop_after_grant: assert property (@(posedge Clk) disable iff (RESET)
		(data_grant |=> !data_req) and (fetch_grant |=> !fetch_req));

endmodule

`default_nettype wire

//--- design/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire                   mar_load,
	input  wire                   mem_write,
	input  wire                   mdr_load,
	input  wire sparc_pkg::word_t alu_result,
	input  wire sparc_pkg::word_t rs2_data,
	input  wire                   data_grant,
	input  wire                   data_done,
	input  wire sparc_pkg::word_t data_rdata,
	output logic                  data_req,
	output sparc_pkg::addr_t      data_addr,
	output logic                  data_write,
	output sparc_pkg::word_t      data_wdata,
	output sparc_pkg::word_t      mdr_data
);

	sparc_pkg::addr_t mar;
	sparc_pkg::word_t mdr;

	assign data_addr  = mar;
	assign data_wdata = mdr; // Store data sits in MDR
	assign mdr_data   = mdr;

	always_ff @(posedge Clk) begin
		if (RESET) begin
			data_req   <= 1'b0;
			data_write <= 1'b0;
		end else begin
			if (mar_load) begin
				data_req   <= 1'b1;      // One request per access
				data_write <= mem_write;
			end else if (data_grant) begin
				data_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (mar_load)
			mar <= alu_result;
		if (mdr_load)
			mdr <= rs2_data;   // rd value for st
		else if (data_done && !data_write)
			mdr <= data_rdata; // Load result
	end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire                   pc_advance,
	input  wire                   npc_load,
	input  wire sparc_pkg::addr_t npc_target,
	input  wire                   ir_take,
	input  wire                   annul_next,
	input  wire                   fetch_grant,
	input  wire                   fetch_done,
	input  wire sparc_pkg::word_t fetch_rdata,
	output sparc_pkg::addr_t      pc,
	output logic                  fetch_req,
	output sparc_pkg::addr_t      fetch_addr,
	output logic                  ir_valid,
	output sparc_pkg::word_t      ir
);

	sparc_pkg::addr_t npc;
	sparc_pkg::word_t pf_buf;   // Word at nPC
	logic buf_valid;
	logic pending;             // Granted, waiting for fetch_done
	logic drop;                // Pending response belongs to a flushed nPC
	logic fetch_on;            // Low through reset
	logic flush;

	assign flush      = annul_next || npc_load;
	assign fetch_req  = fetch_on && !buf_valid && !pending;
	assign fetch_addr = npc;
	assign ir_valid   = buf_valid;

	always_ff @(posedge Clk) begin
		if (RESET) begin
			pc        <= sparc_pkg::RESET_PC;
			npc       <= sparc_pkg::RESET_PC; // First take moves this into PC
			buf_valid <= 1'b0;
			pending   <= 1'b0;
			drop      <= 1'b0;
			fetch_on  <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
			if (pc_advance)
				pc <= npc;
			if (npc_load)
				npc <= npc_target;
			else if (pc_advance || annul_next)
				npc <= npc + 32'd4; // Step past the taken or annulled word

			if (fetch_grant)
				pending <= 1'b1;
			else if (fetch_done)
				pending <= 1'b0;

			if (fetch_done)
				drop <= 1'b0;
			if (flush && (fetch_grant || (pending && !fetch_done)))
				drop <= 1'b1; // Response still in flight for the old nPC

			if (flush || ir_take)
				buf_valid <= 1'b0;
			else if (fetch_done && !drop)
				buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (fetch_done)
			pf_buf <= fetch_rdata;
		if (ir_take)
			ir <= pf_buf;
	end

	// A response only comes back for a granted fetch
	a_done_while_pending: assert property (@(posedge Clk) disable iff (RESET)
		fetch_done |-> pending);

endmodule

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire sparc_pkg::word_t ir,
	input  wire                   ir_valid,
	input  wire sparc_pkg::addr_t pc,
	input  wire                   data_done,
	output logic                  ir_take,
	output logic                  pc_advance,
	output logic                  npc_load,
	output sparc_pkg::addr_t      npc_target,
	output logic                  annul_next,
	output sparc_pkg::reg_addr_t  rs1_addr,
	output sparc_pkg::reg_addr_t  rs2_addr,
	output sparc_pkg::reg_addr_t  rd_addr,
	output logic                  rf_write,
	output sparc_pkg::wb_sel_t    wb_select,
	output sparc_pkg::alu_op_t    alu_op,
	output logic                  imm_select,
	output logic                  mar_load,
	output logic                  mem_write,
	output logic                  mdr_load,
	output logic                  retire,
	output sparc_pkg::addr_t      retire_pc
);

	logic [1:0] op;
	sparc_pkg::op3_t op3;
	logic annul;
	logic is_call, is_branch, branch_ba, branch_bn;
	logic is_alu, is_ld, is_st;
	sparc_pkg::addr_t branch_target, call_target;
	sparc_pkg::ctrl_state_t state, state_nx;
	logic redirect;                  // Target waits for the delay slot take
	sparc_pkg::addr_t redirect_addr;

	assign op    = ir[31:30];
	assign op3   = ir[24:19];
	assign annul = ir[29]; // a bit of Bicc

	assign is_call   = op == sparc_pkg::OP_CALL;
	assign is_branch = op == sparc_pkg::OP_BRANCH;
	assign branch_ba = is_branch && ir[28:25] == sparc_pkg::COND_BA;
	assign branch_bn = is_branch && ir[28:25] == sparc_pkg::COND_BN;
	assign is_ld     = op == sparc_pkg::OP_MEM && op3 == sparc_pkg::OP3_LD;
	assign is_st     = op == sparc_pkg::OP_MEM && op3 == sparc_pkg::OP3_ST;
	assign is_alu    = op == sparc_pkg::OP_ARITH && op3 inside {sparc_pkg::OP3_ADD,
		sparc_pkg::OP3_AND, sparc_pkg::OP3_OR, sparc_pkg::OP3_XOR, sparc_pkg::OP3_SUB};

	// Targets are relative to the address of the CTI itself
	assign branch_target = pc + {{8{ir[21]}}, ir[21:0], 2'b00};
	assign call_target   = pc + {ir[29:0], 2'b00};

	assign npc_target = (state == sparc_pkg::FETCH) ? redirect_addr : branch_target;
	assign retire_pc  = pc;

	always_comb begin
		state_nx   = state;
		ir_take    = 1'b0;
		pc_advance = 1'b0;
		npc_load   = 1'b0;
		annul_next = 1'b0;
		rs1_addr   = ir[18:14];
		rs2_addr   = ir[4:0];
		rd_addr    = ir[29:25];
		rf_write   = 1'b0;
		wb_select  = sparc_pkg::WB_ALU;
		imm_select = ir[13]; // i bit
		mar_load   = 1'b0;
		mem_write  = 1'b0;
		mdr_load   = 1'b0;
		retire     = 1'b0;
		case (op3)
			sparc_pkg::OP3_AND: alu_op = sparc_pkg::ALU_AND;
			sparc_pkg::OP3_OR:  alu_op = sparc_pkg::ALU_OR;
			sparc_pkg::OP3_XOR: alu_op = sparc_pkg::ALU_XOR;
			sparc_pkg::OP3_SUB: alu_op = sparc_pkg::ALU_SUB;
			default:            alu_op = sparc_pkg::ALU_ADD;
		endcase
		if (op == sparc_pkg::OP_MEM)
			alu_op = sparc_pkg::ALU_ADD; // Address is rs1 + rs2/simm13

		case (state)
			sparc_pkg::FETCH: begin
				if (ir_valid) begin
					ir_take    = 1'b1;
					pc_advance = 1'b1;
					npc_load   = redirect; // Delay slot taken, jump after it
					state_nx   = sparc_pkg::EXECUTE;
				end
			end
			sparc_pkg::EXECUTE: begin
				if (is_call) begin
					rd_addr   = sparc_pkg::LINK_REG;
					wb_select = sparc_pkg::WB_PC;
					rf_write  = 1'b1;
					retire    = 1'b1;
					state_nx  = sparc_pkg::FETCH;
				end else if (is_st || is_ld) begin
					rs2_addr = ir[29:25]; // Store data is rd
					mdr_load = is_st;
					state_nx = sparc_pkg::MEM_ADDR;
				end else if (is_alu) begin
					state_nx = sparc_pkg::WRITE_BACK;
				end else begin
					// Branches, and anything unsupported retires as a nop
					annul_next = annul && (branch_ba || branch_bn);
					npc_load   = annul && branch_ba; // BA,a goes straight to target
					retire     = 1'b1;
					state_nx   = sparc_pkg::FETCH;
				end
			end
			sparc_pkg::MEM_ADDR: begin
				mar_load  = 1'b1;
				mem_write = is_st;
				state_nx  = sparc_pkg::MEM_WAIT;
			end
			sparc_pkg::MEM_WAIT: begin
				if (data_done) begin
					retire   = is_st;
					state_nx = is_st ? sparc_pkg::FETCH : sparc_pkg::WRITE_BACK;
				end
			end
			sparc_pkg::WRITE_BACK: begin
				rf_write  = rd_addr != '0; // r0 never written
				wb_select = is_ld ? sparc_pkg::WB_MDR : sparc_pkg::WB_ALU;
				retire    = 1'b1;
				state_nx  = sparc_pkg::FETCH;
			end
			default: state_nx = sparc_pkg::FETCH;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			state    <= sparc_pkg::FETCH;
			redirect <= 1'b0;
		end else begin
			state <= state_nx;
			if (ir_take)
				redirect <= 1'b0; // Consumed by the delay slot take
			else if (state == sparc_pkg::EXECUTE && (is_call || (branch_ba && !annul)))
				redirect <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (state == sparc_pkg::EXECUTE)
			redirect_addr <= is_call ? call_target : branch_target;
	end

	a_no_r0_write: assert property (@(posedge Clk) disable iff (RESET)
		rf_write |-> rd_addr != '0);
	// MEM_ADDR is only reached with a ld or st still in the IR
	a_mar_in_mem_addr: assert property (@(posedge Clk) disable iff (RESET)
		mar_load |-> (is_ld || is_st));

endmodule

`default_nettype wire

//--- design/sparc_core.sv
`timescale 1ns/100ps
`default_nettype none

module sparc_core (
	input  wire                   Clk,
	input  wire                   RESET,
	input  wire                   boot_write,
	input  wire sparc_pkg::addr_t boot_addr,
	input  wire sparc_pkg::word_t boot_data,
	output logic                  retire,
	output sparc_pkg::addr_t      retire_pc,
	output logic                  retire_write,
	output sparc_pkg::reg_addr_t  retire_rd,
	output sparc_pkg::word_t      retire_data,
	output logic                  mem_store,
	output sparc_pkg::addr_t      store_addr,
	output sparc_pkg::word_t      store_data
);

	sparc_pkg::word_t ir, rs1_data, rs2_data, alu_result, mdr_data, write_data;
	sparc_pkg::addr_t pc, npc_target, fetch_addr, data_addr, mem_addr;
	sparc_pkg::word_t data_wdata, mem_wdata, mem_rdata, fetch_rdata, data_rdata;
	sparc_pkg::reg_addr_t rs1_addr, rs2_addr, rd_addr;
	sparc_pkg::alu_op_t alu_op;
	sparc_pkg::wb_sel_t wb_select;
	logic ir_valid, ir_take, pc_advance, npc_load, annul_next;
	logic rf_write, imm_select, mar_load, mem_write, mdr_load;
	logic fetch_req, fetch_grant, fetch_done;
	logic data_req, data_write, data_grant, data_done;
	logic mem_en, mem_we;

	// Write-back source
	assign write_data = (wb_select == sparc_pkg::WB_PC) ? retire_pc :
		(wb_select == sparc_pkg::WB_MDR) ? mdr_data : alu_result;

	assign retire_write = rf_write;
	assign retire_rd    = rd_addr;
	assign retire_data  = write_data;
	assign mem_store    = data_done && data_write; // Same cycle as st retire
	assign store_addr   = data_addr;
	assign store_data   = data_wdata;

	control_unit u_ctrl (.Clk, .RESET, .ir, .ir_valid, .pc, .data_done, .ir_take,
		.pc_advance, .npc_load, .npc_target, .annul_next, .rs1_addr, .rs2_addr, .rd_addr,
		.rf_write, .wb_select, .alu_op, .imm_select, .mar_load, .mem_write, .mdr_load,
		.retire, .retire_pc);

	fetch_unit u_fetch (.Clk, .RESET, .pc_advance, .npc_load, .npc_target, .ir_take,
		.annul_next, .fetch_grant, .fetch_done, .fetch_rdata, .pc, .fetch_req,
		.fetch_addr, .ir_valid, .ir);

	load_store_unit u_lsu (.Clk, .RESET, .mar_load, .mem_write, .mdr_load, .alu_result,
		.rs2_data, .data_grant, .data_done, .data_rdata, .data_req, .data_addr,
		.data_write, .data_wdata, .mdr_data);

	register_file u_rf (.Clk, .RESET, .rs1_addr, .rs2_addr, .rd_addr, .rf_write,
		.write_data, .rs1_data, .rs2_data);

	alu u_alu (.ir, .rs1_data, .rs2_data, .alu_op, .imm_select, .alu_result);

	memory_arbiter u_arb (.Clk, .RESET, .fetch_req, .fetch_addr, .data_req, .data_addr,
		.data_write, .data_wdata, .mem_rdata, .fetch_grant, .data_grant, .mem_en, .mem_we,
		.mem_addr, .mem_wdata, .fetch_done, .data_done, .fetch_rdata, .data_rdata);

	ram u_ram (.Clk, .RESET, .mem_en, .mem_we, .mem_addr, .mem_wdata, .boot_write,
		.boot_addr, .boot_data, .mem_rdata);

endmodule

`default_nettype wire

//--- verif/tb_sparc_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sparc_core;

	localparam int NUM_RETIRE     = 200; // Instructions checked
	localparam int PROG_LIMIT     = 140; // Random code ends here, spin tail after it
	localparam int DATA_BASE      = 192; // First data word, code stays below
	localparam int BOOT_CYCLES    = sparc_pkg::RAM_WORDS;
	localparam int TIMEOUT_CYCLES = BOOT_CYCLES + 4 + 12 * NUM_RETIRE;

	logic Clk = 1'b0;
	logic RESET;
	logic boot_write;
	sparc_pkg::addr_t boot_addr;
	sparc_pkg::word_t boot_data;
	logic retire, retire_write, mem_store;
	sparc_pkg::addr_t retire_pc, store_addr;
	sparc_pkg::reg_addr_t retire_rd;
	sparc_pkg::word_t retire_data, store_data;

	logic [15:0] lfsr;                           // Galois LFSR state
	sparc_pkg::word_t image [sparc_pkg::RAM_WORDS]; // Boot image
	sparc_pkg::word_t m_mem [sparc_pkg::RAM_WORDS]; // ISA model memory
	sparc_pkg::word_t m_reg [32];
	sparc_pkg::addr_t m_pc, m_npc;

	// Expected retire records, in program order
	sparc_pkg::addr_t     exp_pc    [NUM_RETIRE];
	logic                 exp_write [NUM_RETIRE];
	sparc_pkg::reg_addr_t exp_rd    [NUM_RETIRE];
	sparc_pkg::word_t     exp_data  [NUM_RETIRE];
	logic                 exp_store [NUM_RETIRE];
	sparc_pkg::addr_t     exp_saddr [NUM_RETIRE];
	sparc_pkg::word_t     exp_sdata [NUM_RETIRE];

	int errors;
	int n_checked;
	int cycle_count;

	sparc_core dut (.Clk, .RESET, .boot_write, .boot_addr, .boot_data, .retire, .retire_pc,
		.retire_write, .retire_rd, .retire_data, .mem_store, .store_addr, .store_data);

	always #4 Clk = ~Clk; // 8 ns period

	// One LFSR step per bit, LSB is the bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Random ALU op, register or simm13 form
	function automatic sparc_pkg::word_t alu_word();
		int sel;
		sparc_pkg::op3_t op3;
		sparc_pkg::reg_addr_t rd, rs1, rs2;
		logic imm;
		logic [12:0] simm13;
		sel    = rand_bits(3) % 5;
		rd     = rand_bits(5);
		rs1    = rand_bits(5);
		imm    = rand_bits(1);
		simm13 = rand_bits(13);
		rs2    = rand_bits(5);
		case (sel)
			0: op3 = sparc_pkg::OP3_ADD;
			1: op3 = sparc_pkg::OP3_AND;
			2: op3 = sparc_pkg::OP3_OR;
			3: op3 = sparc_pkg::OP3_XOR;
			default: op3 = sparc_pkg::OP3_SUB;
		endcase
		if (imm)
			return {sparc_pkg::OP_ARITH, rd, op3, rs1, 1'b1, simm13};
		return {sparc_pkg::OP_ARITH, rd, op3, rs1, 1'b0, 8'h00, rs2};
	endfunction

	task automatic build_program();
		int p;
		int kind;
		int d;
		sparc_pkg::reg_addr_t rd, rd2;
		logic [5:0] k;
		logic a;
		logic [12:0] offs;
		p = 0;
		while (p < PROG_LIMIT) begin
			kind = rand_bits(3);
			case (kind)
				4: begin // st then ld of the same data word
					rd   = rand_bits(5);
					rd2  = rand_bits(5);
					k    = rand_bits(6);
					offs = 13'(DATA_BASE * 4 + 4 * k);
					image[p]     = {sparc_pkg::OP_MEM, rd, sparc_pkg::OP3_ST, 5'd0, 1'b1, offs};
					image[p + 1] = {sparc_pkg::OP_MEM, rd2, sparc_pkg::OP3_LD, 5'd0, 1'b1, offs};
					p += 2;
				end
				5: begin
					d = 2 + rand_bits(2);                 // Forward target only
					image[p]     = {sparc_pkg::OP_CALL, 30'(d)};
					image[p + 1] = alu_word();            // Delay slot
					p += 2;
				end
				6, 7: begin
					a = rand_bits(1);
					d = 2 + rand_bits(2);
					image[p] = {sparc_pkg::OP_BRANCH, a,
						(kind == 6) ? sparc_pkg::COND_BA : sparc_pkg::COND_BN, 3'b010, 22'(d)};
					image[p + 1] = alu_word();
					p += 2;
				end
				default: begin
					image[p] = alu_word();
					p += 1;
				end
			endcase
		end
		// BA,a to itself catches every path that runs past the random code
		for (int w = p; w < DATA_BASE; w++)
			image[w] = {sparc_pkg::OP_BRANCH, 1'b1, sparc_pkg::COND_BA, 3'b010, 22'd0};
		for (int w = DATA_BASE; w < sparc_pkg::RAM_WORDS; w++)
			image[w] = 32'h9E37_79B9 * (w + 1) ^ (w << 20); // Mixes every address bit
	endtask

	// ISA model, one record per completed instruction
	function automatic void run_model();
		sparc_pkg::word_t inst, b, res, target;
		sparc_pkg::addr_t next_pc, next_npc;
		sparc_pkg::reg_addr_t rd, rs1;
		sparc_pkg::op3_t op3;
		for (int n = 0; n < NUM_RETIRE; n++) begin
			inst     = m_mem[m_pc[9:2]];
			rd       = inst[29:25];
			rs1      = inst[18:14];
			op3      = inst[24:19];
			b        = inst[13] ? {{19{inst[12]}}, inst[12:0]} : m_reg[inst[4:0]];
			next_pc  = m_npc;
			next_npc = m_npc + 32'd4;
			exp_pc[n]    = m_pc;
			exp_write[n] = 1'b0;
			exp_rd[n]    = '0;
			exp_data[n]  = '0;
			exp_store[n] = 1'b0;
			exp_saddr[n] = '0;
			exp_sdata[n] = '0;
			case (inst[31:30])
				sparc_pkg::OP_ARITH: begin
					case (op3)
						sparc_pkg::OP3_AND: res = m_reg[rs1] & b;
						sparc_pkg::OP3_OR:  res = m_reg[rs1] | b;
						sparc_pkg::OP3_XOR: res = m_reg[rs1] ^ b;
						sparc_pkg::OP3_SUB: res = m_reg[rs1] - b;
						default:            res = m_reg[rs1] + b;
					endcase
					if (rd != 0) begin // r0 writes vanish
						m_reg[rd]    = res;
						exp_write[n] = 1'b1;
						exp_rd[n]    = rd;
						exp_data[n]  = res;
					end
				end
				sparc_pkg::OP_MEM: begin
					target = m_reg[rs1] + b;
					if (op3 == sparc_pkg::OP3_ST) begin
						m_mem[target[9:2]] = m_reg[rd];
						exp_store[n] = 1'b1;
						exp_saddr[n] = target;
						exp_sdata[n] = m_reg[rd];
					end else if (rd != 0) begin
						m_reg[rd]    = m_mem[target[9:2]];
						exp_write[n] = 1'b1;
						exp_rd[n]    = rd;
						exp_data[n]  = m_reg[rd];
					end
				end
				sparc_pkg::OP_CALL: begin
					m_reg[15]    = m_pc;      // Link
					exp_write[n] = 1'b1;
					exp_rd[n]    = 5'd15;
					exp_data[n]  = m_pc;
					next_npc     = m_pc + (inst << 2);
				end
				default: begin
					target = m_pc + ({{10{inst[21]}}, inst[21:0]} << 2);
					if (inst[28:25] == sparc_pkg::COND_BA) begin
						if (inst[29]) begin // Delay slot annulled
							next_pc  = target;
							next_npc = target + 32'd4;
						end else begin
							next_npc = target;
						end
					end else if (inst[29]) begin
						next_pc  = m_npc + 32'd4; // BN,a skips the delay slot
						next_npc = m_npc + 32'd8;
					end
				end
			endcase
			m_pc  = next_pc;
			m_npc = next_npc;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s at retire %0d: got %h, expected %h", name, n_checked, got, exp);
		end
	endtask

	// Compare each retire with the next model record, mid-cycle where outputs are stable
	always @(negedge Clk) begin
		if (!RESET && retire && n_checked < NUM_RETIRE) begin
			check_value("retire_pc", retire_pc, exp_pc[n_checked]);
			check_value("retire_write", 32'(retire_write), 32'(exp_write[n_checked]));
			if (exp_write[n_checked]) begin
				check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[n_checked]));
				check_value("retire_data", retire_data, exp_data[n_checked]);
			end
			check_value("mem_store", 32'(mem_store), 32'(exp_store[n_checked]));
			if (exp_store[n_checked]) begin
				check_value("store_addr", store_addr, exp_saddr[n_checked]);
				check_value("store_data", store_data, exp_sdata[n_checked]);
			end
			n_checked++;
		end
	end

	initial begin
		RESET      = 1'b1;
		boot_write = 1'b0;
		boot_addr  = '0;
		boot_data  = '0;
		errors     = 0;
		n_checked  = 0;
		lfsr       = 16'd21; // Seed
		build_program();
		for (int w = 0; w < sparc_pkg::RAM_WORDS; w++)
			m_mem[w] = image[w];
		for (int r = 0; r < 32; r++)
			m_reg[r] = '0;
		m_pc  = sparc_pkg::RESET_PC;
		m_npc = sparc_pkg::RESET_PC + 32'd4;
		run_model();
		for (int w = 0; w < sparc_pkg::RAM_WORDS; w++) begin
			@(posedge Clk);
			#1;
			boot_write = 1'b1;
			boot_addr  = w * 4;
			boot_data  = image[w];
		end
		@(posedge Clk);
		#1;
		boot_write = 1'b0; // Last word lands at this edge
		repeat (3) @(posedge Clk);
		#1;
		RESET = 1'b0;
		wait (n_checked == NUM_RETIRE);
		@(posedge Clk);
		$display("Checked %0d retires, %0d errors", n_checked, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Run limit, boot time plus 12 cycles per instruction
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge Clk);
			cycle_count++;
		end
		$display("Timeout: only %0d of %0d instructions retired in %0d cycles",
			n_checked, NUM_RETIRE, cycle_count);
		$display("Checked %0d retires, %0d errors", n_checked, errors);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/sparc_pkg.sv
design/alu.sv
design/register_file.sv
design/ram.sv
design/memory_arbiter.sv
design/load_store_unit.sv
design/fetch_unit.sv
design/control_unit.sv
design/sparc_core.sv
verif/tb_sparc_core.sv

//--- Bender.yml
package:
  name: sparc_core

sources:
  - design/sparc_pkg.sv
  - design/alu.sv
  - design/register_file.sv
  - design/ram.sv
  - design/memory_arbiter.sv
  - design/load_store_unit.sv
  - design/fetch_unit.sv
  - design/control_unit.sv
  - design/sparc_core.sv
  - target: test
    files:
      - verif/tb_sparc_core.sv
